// ==== Makefile ====
# Verilator build and run of the vector execute testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_vector_execute -o sim_vex
	./obj_dir/sim_vex | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== address_gen.sv ====
/* load/store address generation for the two lanes of a beat
   keeps the last lane 1 address so strided streams continue across beats */
`timescale 1ns/1ns

module address_gen (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  stall,
  input  logic                  accept,
  input  logic                  first,
  input  vex_op_pkg::stride_t   stride_kind,
  input  vex_width_pkg::word_t  stride_val,
  input  vex_width_pkg::sew_t   eew_ls,
  input  vex_width_pkg::field_t nf,
  input  vex_width_pkg::field_t field,
  input  vex_width_pkg::word_t  xs1,
  input  vex_width_pkg::word_t  index0,
  input  vex_width_pkg::word_t  index1,
  output vex_width_pkg::word_t  addr0,
  output vex_width_pkg::word_t  addr1
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  logic [1:0] shift;
  word_t      base;
  word_t      stride;
  word_t      addr_buf;

  assign shift = sew_shift(eew_ls);
  // segment field offset from the scalar base
  assign base  = xs1 + (word_t'(field) << shift);

  always_comb begin
    case (stride_kind)
      STRIDE_CONST: stride = stride_val;
      STRIDE_SEG:   stride = (word_t'(nf) + word_t'(1)) << shift;
      default:      stride = word_t'(1) << shift;
    endcase
  end

  always_comb begin
    if (stride_kind == STRIDE_INDEX) begin
      addr0 = base + index0;
      addr1 = base + index1;
    end else begin
      addr0 = first ? base : addr_buf + stride;
      addr1 = addr0 + stride;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buf <= '0;
    end else if (flush) begin
      addr_buf <= '0;
    end else if (accept) begin
      addr_buf <= addr1;
    end
  end

  // accept comes from the top, which has to gate it with stall
  assert property (@(posedge CLK) disable iff (!nRST)
    stall && !flush |=> $stable(addr_buf))
    else $error("address_gen: address buffer moved during stall");

endmodule

// ==== lane_alu.sv ====
/* arithmetic and logic for one lane at 8, 16 or 32 bit element width
   used once per lane and once more for the cross-lane reduction */
`timescale 1ns/1ns

module lane_alu (
  input  vex_op_pkg::aluop_t   aluop,
  input  vex_op_pkg::minmax_t  minmax,
  input  vex_width_pkg::sew_t  sew,
  input  vex_width_pkg::word_t a,
  input  vex_width_pkg::word_t b,
  output vex_width_pkg::word_t y
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  word_t emask;
  word_t sbit;
  word_t a_z;
  word_t b_z;
  logic  lt_u;
  logic  lt_s;

  always_comb begin
    case (sew)
      SEW8:    emask = word_t'(32'h0000_00ff);
      SEW16:   emask = word_t'(32'h0000_ffff);
      default: emask = '1;
    endcase
    // top bit of the element
    sbit = emask ^ (emask >> 1);
    a_z  = a & emask;
    b_z  = b & emask;
    lt_u = a_z < b_z;
    // flipping the sign bit turns a signed compare into an unsigned one
    lt_s = (a_z ^ sbit) < (b_z ^ sbit);
  end

  always_comb begin
    case (aluop)
      ALU_ADD: y = (a + b) & emask;
      ALU_AND: y = a_z & b_z;
      ALU_OR:  y = a_z | b_z;
      ALU_XOR: y = a_z ^ b_z;
      ALU_MM: begin
        case (minmax)
          MIN:     y = lt_s ? a_z : b_z;
          MINU:    y = lt_u ? a_z : b_z;
          MAX:     y = lt_s ? b_z : a_z;
          default: y = lt_u ? b_z : a_z;
        endcase
      end
      default: y = '0;
    endcase
  end

  // decode must hand over a known op code from the used range
  always_comb begin
    assert final (!$isunknown(aluop) && aluop <= ALU_MM)
      else $error("lane_alu: illegal aluop %0h", aluop);
  end

endmodule

// ==== list.f ====
vex_width_pkg.sv
vex_op_pkg.sv
operand_select.sv
lane_alu.sv
segment_counter.sv
address_gen.sv
mask_scan_fsm.sv
result_latch.sv
vector_execute.sv
tb_vector_execute.sv

// ==== mask_scan_fsm.sv ====
/* first-set-bit scan for sbf, sif and sof over a multi-beat mask
   remembers across beats whether the first set bit was already seen */
`timescale 1ns/1ns

module mask_scan_fsm (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  input  logic                   accept,
  input  logic                   last,
  input  logic                   is_mask,
  input  vex_op_pkg::mask_op_t   mask_op,
  input  vex_width_pkg::word_t   m_lo,
  input  vex_width_pkg::word_t   m_hi,
  output vex_width_pkg::word_t   mres_lo,
  output vex_width_pkg::word_t   mres_hi
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  typedef enum logic {
    SEARCH = 1'b0,
    FOUND  = 1'b1
  } state_t;

  state_t                state;
  state_t                next_state;
  logic [LANES*XLEN-1:0] bits;
  logic [LANES*XLEN-1:0] first_one;
  logic [LANES*XLEN-1:0] below_first;
  logic [LANES*XLEN-1:0] res;

  assign bits        = {m_hi, m_lo};
  // isolate the lowest set bit
  assign first_one   = bits & (~bits + 1'b1);
  // all ones when nothing is set
  assign below_first = first_one - 1'b1;

  always_comb begin
    next_state = state;
    if (accept && last) begin
      next_state = SEARCH;
    end else if (accept && is_mask && bits != '0) begin
      next_state = FOUND;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= SEARCH;
    end else if (flush) begin
      state <= SEARCH;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    res = '0;
    // once found, every later bit is clear for all three ops
    if (state == SEARCH) begin
      case (mask_op)
        MASK_SBF: res = below_first;
        MASK_SIF: res = below_first | first_one;
        MASK_SOF: res = first_one;
        default:  res = '0;
      endcase
    end
  end

  assign mres_lo = res[XLEN-1:0];
  assign mres_hi = res[LANES*XLEN-1:XLEN];

endmodule

// ==== operand_select.sv ====
/* operand 1 source selection for both lanes
   also scales the vs2 index values to byte offsets for indexed load/store */
`timescale 1ns/1ns

module operand_select (
  input  vex_op_pkg::src_t     rs1_src,
  input  vex_width_pkg::sew_t  sew,
  input  vex_width_pkg::word_t vs1_lane0,
  input  vex_width_pkg::word_t vs1_lane1,
  input  vex_width_pkg::word_t imm,
  input  vex_width_pkg::word_t xs1,
  input  vex_width_pkg::word_t xs2,
  input  vex_width_pkg::word_t vs2_lane0,
  input  vex_width_pkg::word_t vs2_lane1,
  output vex_width_pkg::word_t op_a0,
  output vex_width_pkg::word_t op_a1,
  output vex_width_pkg::word_t index0,
  output vex_width_pkg::word_t index1
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  always_comb begin
    case (rs1_src)
      SRC_V: begin
        op_a0 = vs1_lane0;
        op_a1 = vs1_lane1;
      end
      // scalar sources are broadcast
      SRC_I: begin
        op_a0 = imm;
        op_a1 = imm;
      end
      SRC_X: begin
        op_a0 = xs1;
        op_a1 = xs1;
      end
      // spare encoding takes the second scalar
      default: begin
        op_a0 = xs2;
        op_a1 = xs2;
      end
    endcase
  end

  // element index times element bytes
  assign index0 = vs2_lane0 << sew_shift(sew);
  assign index1 = vs2_lane1 << sew_shift(sew);

endmodule

// ==== result_latch.sv ====
/* execute/memory pipeline register with reduction and result select
   holds on stall, clears on flush, otherwise captures the accepted beat */
`timescale 1ns/1ns

module result_latch (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  in_valid,
  input  vex_op_pkg::fu_t       fu,
  input  vex_op_pkg::aluop_t    aluop,
  input  vex_op_pkg::minmax_t   minmax,
  input  vex_width_pkg::sew_t   sew,
  input  logic                  reduce,
  input  vex_width_pkg::word_t  y0,
  input  vex_width_pkg::word_t  y1,
  input  vex_width_pkg::word_t  mres_lo,
  input  vex_width_pkg::word_t  mres_hi,
  input  vex_width_pkg::word_t  gen_addr0,
  input  vex_width_pkg::word_t  gen_addr1,
  output logic                  out_valid,
  output vex_width_pkg::word_t  result0,
  output vex_width_pkg::word_t  result1,
  output vex_width_pkg::word_t  addr0,
  output vex_width_pkg::word_t  addr1,
  output logic                  load_ena,
  output logic                  store_ena
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  word_t red_y;
  word_t next_r0;
  word_t next_r1;
  word_t next_a0;
  word_t next_a1;
  logic  is_ls;

  // lane 1 folded into lane 0 with the lane op itself
  lane_alu reduce_inst (
    .aluop  (aluop),
    .minmax (minmax),
    .sew    (sew),
    .a      (y0),
    .b      (y1),
    .y      (red_y)
  );

  assign is_ls = (fu == FU_LOAD) || (fu == FU_STORE);

  always_comb begin
    next_r0 = y0;
    next_r1 = y1;
    if (fu == FU_MASK) begin
      next_r0 = mres_lo;
      next_r1 = mres_hi;
    end else if (fu == FU_ALU && reduce) begin
      next_r0 = red_y;
    end
    next_a0 = is_ls ? gen_addr0 : '0;
    next_a1 = is_ls ? gen_addr1 : '0;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      load_ena  <= 1'b0;
      store_ena <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      addr0     <= '0;
      addr1     <= '0;
    end else if (flush) begin
      out_valid <= 1'b0;
      load_ena  <= 1'b0;
      store_ena <= 1'b0;
      result0   <= '0;
      result1   <= '0;
      addr0     <= '0;
      addr1     <= '0;
    end else if (!stall) begin
      out_valid <= in_valid;
      load_ena  <= in_valid && fu == FU_LOAD;
      store_ena <= in_valid && fu == FU_STORE;
      // bubbles keep the last data
      if (in_valid) begin
        result0 <= next_r0;
        result1 <= next_r1;
        addr0   <= next_a0;
        addr1   <= next_a1;
      end
    end
  end

  // memory sees at most one access kind, and only on a valid beat
  assert property (@(posedge CLK) disable iff (!nRST)
    (load_ena || store_ena) |-> out_valid && !(load_ena && store_ena))
    else $error("result_latch: load_ena %b store_ena %b out_valid %b",
                load_ena, store_ena, out_valid);

endmodule

// ==== segment_counter.sv ====
/* segment field counter for load/store
   steps once per completed instruction and wraps after field nf */
`timescale 1ns/1ns

module segment_counter (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  flush,
  input  logic                  step,
  input  vex_width_pkg::field_t nf,
  output vex_width_pkg::field_t field
);
  import vex_width_pkg::*;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      field <= '0;
    end else if (flush) begin
      field <= '0;
    end else if (step) begin
      // >= also recovers when nf shrinks between instructions
      if (field >= nf) begin
        field <= '0;
      end else begin
        field <= field_t'(field + 1'b1);
      end
    end
  end

endmodule

// ==== tb_vector_execute.sv ====
/* testbench for the two-lane vector execute stage
   drives random and directed beats on the falling edge and checks every
   output register against a cycle model with concurrent assertions */
`timescale 1ns/1ns

module tb_vector_execute;
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  localparam int N_ARITH     = 200;
  // reset, arithmetic, mask, address, stall/flush, field sweep, drain
  localparam int STIM_CYCLES = 5 + N_ARITH + 12 + 15 + 7 + 9 + 3;
  localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

  logic     CLK;
  logic     nRST;
  logic     in_valid;
  logic     first;
  logic     last;
  logic     reduce;
  logic     stall;
  logic     flush;
  fu_t      fu;
  aluop_t   aluop;
  minmax_t  minmax;
  sew_t     sew;
  sew_t     eew_ls;
  src_t     rs1_src;
  mask_op_t mask_op;
  stride_t  stride_kind;
  field_t   nf;
  word_t    vs1_lane0;
  word_t    vs1_lane1;
  word_t    vs2_lane0;
  word_t    vs2_lane1;
  word_t    imm;
  word_t    xs1;
  word_t    xs2;
  word_t    stride_val;
  logic     out_valid;
  logic     load_ena;
  logic     store_ena;
  word_t    result0;
  word_t    result1;
  word_t    addr0;
  word_t    addr1;

  // cycle model of the output register and the stage state
  logic        exp_valid;
  logic        exp_load;
  logic        exp_store;
  word_t       exp_r0;
  word_t       exp_r1;
  word_t       exp_a0;
  word_t       exp_a1;
  word_t       pend_r0;
  word_t       pend_r1;
  word_t       pend_a0;
  word_t       pend_a1;
  logic        m_found;
  logic        pend_found;
  field_t      m_field;
  field_t      pend_field;
  word_t       m_buf;
  word_t       pend_buf;
  logic [31:0] lfsr = 32'hdccb7275;
  int          errors = 0;
  int          beats = 0;
  int          cycles = 0;

  vector_execute vector_execute_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] pick(input int unsigned n);
    return lfsr_bits(16) % n;
  endfunction

  // element op on the low w bits with the result zero-extended
  function automatic word_t alu_ref(input aluop_t op, input minmax_t mm, input sew_t sw,
                                    input word_t a, input word_t b);
    int     w;
    word_t  m;
    word_t  ua;
    word_t  ub;
    word_t  r;
    longint sva;
    longint svb;
    w   = (sw == SEW8) ? 8 : (sw == SEW16) ? 16 : 32;
    m   = (w == 32) ? '1 : word_t'((64'd1 << w) - 64'd1);
    ua  = a & m;
    ub  = b & m;
    sva = ua[w-1] ? longint'(ua) - (longint'(1) << w) : longint'(ua);
    svb = ub[w-1] ? longint'(ub) - (longint'(1) << w) : longint'(ub);
    case (op)
      ALU_ADD: r = (a + b) & m;
      ALU_AND: r = ua & ub;
      ALU_OR:  r = ua | ub;
      ALU_XOR: r = ua ^ ub;
      default: begin
        case (mm)
          MIN:     r = (sva < svb) ? ua : ub;
          MINU:    r = (ua < ub) ? ua : ub;
          MAX:     r = (sva > svb) ? ua : ub;
          default: r = (ua > ub) ? ua : ub;
        endcase
      end
    endcase
    return r;
  endfunction

  // bit by bit walk where seen starts set when an earlier beat had the first one
  function automatic logic [63:0] scan_ref(input logic found, input mask_op_t op,
                                           input logic [63:0] v);
    logic [63:0] r;
    logic        seen;
    r    = '0;
    seen = found;
    for (int i = 0; i < 64; i++) begin
      case (op)
        MASK_SBF: r[i] = !seen && !v[i];
        MASK_SIF: r[i] = !seen;
        MASK_SOF: r[i] = !seen && v[i];
        default:  r[i] = 1'b0;
      endcase
      seen = seen || v[i];
    end
    return r;
  endfunction

  // expected outputs and next state if the driven beat is accepted
  task automatic predict();
    word_t       a0;
    word_t       a1;
    word_t       y0;
    word_t       y1;
    word_t       eb;
    word_t       sb;
    word_t       base;
    word_t       strd;
    word_t       g0;
    word_t       g1;
    logic [63:0] mv;
    logic [63:0] ms;
    logic        ls;
    a0 = (rs1_src == SRC_V) ? vs1_lane0 : (rs1_src == SRC_I) ? imm : xs1;
    a1 = (rs1_src == SRC_V) ? vs1_lane1 : (rs1_src == SRC_I) ? imm : xs1;
    y0 = alu_ref(aluop, minmax, sew, vs2_lane0, a0);
    y1 = alu_ref(aluop, minmax, sew, vs2_lane1, a1);
    mv = {vs2_lane1, vs2_lane0};
    ls = (fu == FU_LOAD) || (fu == FU_STORE);
    pend_r0 = y0;
    pend_r1 = y1;
    if (fu == FU_MASK) begin
      ms      = scan_ref(m_found, mask_op, mv);
      pend_r0 = ms[31:0];
      pend_r1 = ms[63:32];
    end else if (fu == FU_ALU && reduce) begin
      pend_r0 = alu_ref(aluop, minmax, sew, y0, y1);
    end
    eb   = word_t'(1) << eew_ls;
    sb   = word_t'(1) << sew;
    base = xs1 + word_t'(m_field) * eb;
    case (stride_kind)
      STRIDE_CONST: strd = stride_val;
      STRIDE_SEG:   strd = (word_t'(nf) + word_t'(1)) * eb;
      default:      strd = eb;
    endcase
    if (stride_kind == STRIDE_INDEX) begin
      g0 = base + vs2_lane0 * sb;
      g1 = base + vs2_lane1 * sb;
    end else begin
      g0 = first ? base : m_buf + strd;
      g1 = g0 + strd;
    end
    pend_a0  = ls ? g0 : '0;
    pend_a1  = ls ? g1 : '0;
    pend_buf = g1;
    pend_field = m_field;
    if (last && ls) begin
      pend_field = (m_field >= nf) ? '0 : m_field + 3'd1;
    end
    pend_found = m_found;
    if (last) begin
      pend_found = 1'b0;
    end else if (fu == FU_MASK && mv != '0) begin
      pend_found = 1'b1;
    end
  endtask

  always @(posedge CLK or negedge nRST) begin
    if (!nRST || flush) begin
      exp_valid <= 1'b0;
      exp_load  <= 1'b0;
      exp_store <= 1'b0;
      exp_r0    <= '0;
      exp_r1    <= '0;
      exp_a0    <= '0;
      exp_a1    <= '0;
      m_found   <= 1'b0;
      m_field   <= '0;
      m_buf     <= '0;
    end else if (!stall) begin
      exp_valid <= in_valid;
      exp_load  <= in_valid && fu == FU_LOAD;
      exp_store <= in_valid && fu == FU_STORE;
      if (in_valid) begin
        exp_r0  <= pend_r0;
        exp_r1  <= pend_r1;
        exp_a0  <= pend_a0;
        exp_a1  <= pend_a1;
        m_found <= pend_found;
        m_field <= pend_field;
        m_buf   <= pend_buf;
      end
    end
  end

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    errors++;
    $display("Fail %s: got %h, expected %h at %0t", name, got, want, $time);
  endtask

  assert property (@(posedge CLK) disable iff (!nRST) out_valid == exp_valid)
    else log_mismatch("out_valid", 32'($sampled(out_valid)), 32'($sampled(exp_valid)));
  assert property (@(posedge CLK) disable iff (!nRST) load_ena == exp_load)
    else log_mismatch("load_ena", 32'($sampled(load_ena)), 32'($sampled(exp_load)));
  assert property (@(posedge CLK) disable iff (!nRST) store_ena == exp_store)
    else log_mismatch("store_ena", 32'($sampled(store_ena)), 32'($sampled(exp_store)));
  assert property (@(posedge CLK) disable iff (!nRST) result0 == exp_r0)
    else log_mismatch("result0", $sampled(result0), $sampled(exp_r0));
  assert property (@(posedge CLK) disable iff (!nRST) result1 == exp_r1)
    else log_mismatch("result1", $sampled(result1), $sampled(exp_r1));
  assert property (@(posedge CLK) disable iff (!nRST) addr0 == exp_a0)
    else log_mismatch("addr0", $sampled(addr0), $sampled(exp_a0));
  assert property (@(posedge CLK) disable iff (!nRST) addr1 == exp_a1)
    else log_mismatch("addr1", $sampled(addr1), $sampled(exp_a1));

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: stimulus still running after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic init_inputs();
    nRST        = 1'b0;
    in_valid    = 1'b0;
    first       = 1'b0;
    last        = 1'b0;
    reduce      = 1'b0;
    stall       = 1'b0;
    flush       = 1'b0;
    fu          = FU_ALU;
    aluop       = ALU_ADD;
    minmax      = MIN;
    sew         = SEW32;
    eew_ls      = SEW8;
    rs1_src     = SRC_V;
    mask_op     = MASK_SBF;
    stride_kind = STRIDE_UNIT;
    nf          = '0;
    vs1_lane0   = '0;
    vs1_lane1   = '0;
    vs2_lane0   = '0;
    vs2_lane1   = '0;
    imm         = '0;
    xs1         = '0;
    xs2         = '0;
    stride_val  = '0;
  endtask

  task automatic rand_operands();
    vs1_lane0 = lfsr_bits(32);
    vs1_lane1 = lfsr_bits(32);
    vs2_lane0 = lfsr_bits(32);
    vs2_lane1 = lfsr_bits(32);
    imm       = lfsr_bits(32);
    xs1       = lfsr_bits(32);
    xs2       = lfsr_bits(32);
  endtask

  // beat is driven, model updated, then on to the next falling edge
  task automatic issue();
    predict();
    if (in_valid && !stall && !flush) begin
      beats++;
    end
    @(negedge CLK);
  endtask

  task automatic mask_beat(input logic f, input logic l, input word_t lo, input word_t hi);
    in_valid  = 1'b1;
    first     = f;
    last      = l;
    vs2_lane0 = lo;
    vs2_lane1 = hi;
    issue();
  endtask

  task automatic ls_instr(input stride_t kind, input int n);
    fu          = lfsr_bits(1) ? FU_STORE : FU_LOAD;
    stride_kind = kind;
    eew_ls      = sew_t'(2'(pick(3)));
    sew         = sew_t'(2'(pick(3)));
    nf          = field_t'(lfsr_bits(3));
    xs1         = lfsr_bits(32);
    stride_val  = lfsr_bits(8);
    in_valid    = 1'b1;
    for (int i = 0; i < n; i++) begin
      vs2_lane0 = lfsr_bits(12);
      vs2_lane1 = lfsr_bits(12);
      first     = (i == 0);
      last      = (i == n - 1);
      issue();
    end
  endtask

  task automatic flush_cycle();
    in_valid = 1'b0;
    flush    = 1'b1;
    // flush must win over a stall in the same cycle
    stall    = 1'b1;
    issue();
    flush = 1'b0;
    stall = 1'b0;
  endtask

  initial begin
    init_inputs();
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    // a bubble first, so the reset values get checked
    issue();

    // lane arithmetic, second half as reductions, random stalls
    for (int n = 0; n < N_ARITH; n++) begin
      rand_operands();
      fu       = FU_ALU;
      aluop    = aluop_t'(3'(pick(5)));
      minmax   = minmax_t'(2'(lfsr_bits(2)));
      sew      = sew_t'(2'(pick(3)));
      rs1_src  = src_t'(2'(pick(3)));
      reduce   = (n >= N_ARITH / 2);
      in_valid = 1'b1;
      first    = 1'b1;
      last     = 1'b1;
      stall    = (lfsr_bits(3) == 32'd0);
      issue();
    end
    stall  = 1'b0;
    reduce = 1'b0;

    // first set bit sits in the second beat of each scan
    fu = FU_MASK;
    for (int k = 0; k < 3; k++) begin
      mask_op = mask_op_t'(2'(k));
      mask_beat(1'b1, 1'b0, '0, '0);
      mask_beat(1'b0, 1'b0, (lfsr_bits(32) | 32'd1) << lfsr_bits(5), lfsr_bits(32));
      mask_beat(1'b0, 1'b1, lfsr_bits(32), lfsr_bits(32));
      // next instruction searches again
      mask_beat(1'b1, 1'b1, '0, lfsr_bits(32) | 32'h8000_0000);
    end

    ls_instr(STRIDE_UNIT, 3);
    ls_instr(STRIDE_CONST, 3);
    ls_instr(STRIDE_SEG, 3);
    ls_instr(STRIDE_INDEX, 3);
    ls_instr(STRIDE_INDEX, 3);

    // outputs hold while beats are refused
    rand_operands();
    fu       = FU_ALU;
    first    = 1'b1;
    last     = 1'b1;
    in_valid = 1'b1;
    issue();
    stall = 1'b1;
    repeat (3) begin
      rand_operands();
      issue();
    end
    stall   = 1'b0;
    fu      = FU_MASK;
    mask_op = MASK_SIF;
    mask_beat(1'b1, 1'b0, 32'h0000_0010, '0);
    flush_cycle();
    mask_beat(1'b1, 1'b1, 32'h0000_0100, '0);

    // segment base walks one eew per field, wraps, restarts after flush
    flush_cycle();
    fu          = FU_LOAD;
    stride_kind = STRIDE_UNIT;
    eew_ls      = SEW16;
    nf          = 3'd3;
    xs1         = 32'h0000_1000;
    first       = 1'b1;
    last        = 1'b1;
    in_valid    = 1'b1;
    repeat (6) issue();
    flush_cycle();
    in_valid = 1'b1;
    issue();

    in_valid = 1'b0;
    repeat (3) issue();

    $display("%0d errors in %0d accepted beats", errors, beats);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vector_execute.sv ====
/* execute stage of the two-lane vector unit
   one beat in per accepted cycle, one registered result beat out a cycle later */
`timescale 1ns/1ns

module vector_execute (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  input  logic                  first,
  input  logic                  last,
  input  vex_op_pkg::fu_t       fu,
  input  vex_op_pkg::aluop_t    aluop,
  input  vex_op_pkg::minmax_t   minmax,
  input  vex_width_pkg::sew_t   sew,
  input  logic                  reduce,
  input  vex_op_pkg::src_t      rs1_src,
  input  vex_op_pkg::mask_op_t  mask_op,
  input  vex_width_pkg::word_t  vs1_lane0,
  input  vex_width_pkg::word_t  vs1_lane1,
  input  vex_width_pkg::word_t  vs2_lane0,
  input  vex_width_pkg::word_t  vs2_lane1,
  input  vex_width_pkg::word_t  imm,
  input  vex_width_pkg::word_t  xs1,
  input  vex_width_pkg::word_t  xs2,
  input  vex_op_pkg::stride_t   stride_kind,
  input  vex_width_pkg::word_t  stride_val,
  input  vex_width_pkg::field_t nf,
  input  vex_width_pkg::sew_t   eew_ls,
  input  logic                  stall,
  input  logic                  flush,
  output logic                  out_valid,
  output vex_width_pkg::word_t  result0,
  output vex_width_pkg::word_t  result1,
  output vex_width_pkg::word_t  addr0,
  output vex_width_pkg::word_t  addr1,
  output logic                  load_ena,
  output logic                  store_ena
);
  import vex_op_pkg::*;
  import vex_width_pkg::*;

  word_t  op_a0;
  word_t  op_a1;
  word_t  index0;
  word_t  index1;
  word_t  y0;
  word_t  y1;
  word_t  gen_addr0;
  word_t  gen_addr1;
  word_t  mres_lo;
  word_t  mres_hi;
  field_t field;
  logic   accept;
  logic   step;
  logic   is_mask;

  assign accept  = in_valid && !stall;
  // field advances once per finished load/store instruction
  assign step    = accept && last && (fu == FU_LOAD || fu == FU_STORE);
  assign is_mask = fu == FU_MASK;

  operand_select operand_select_inst (
    .rs1_src   (rs1_src),
    .sew       (sew),
    .vs1_lane0 (vs1_lane0),
    .vs1_lane1 (vs1_lane1),
    .imm       (imm),
    .xs1       (xs1),
    .xs2       (xs2),
    .vs2_lane0 (vs2_lane0),
    .vs2_lane1 (vs2_lane1),
    .op_a0     (op_a0),
    .op_a1     (op_a1),
    .index0    (index0),
    .index1    (index1)
  );

  lane_alu lane0_inst (
    .aluop  (aluop),
    .minmax (minmax),
    .sew    (sew),
    .a      (vs2_lane0),
    .b      (op_a0),
    .y      (y0)
  );

  lane_alu lane1_inst (
    .aluop  (aluop),
    .minmax (minmax),
    .sew    (sew),
    .a      (vs2_lane1),
    .b      (op_a1),
    .y      (y1)
  );

  segment_counter segment_counter_inst (
    .CLK   (CLK),
    .nRST  (nRST),
    .flush (flush),
    .step  (step),
    .nf    (nf),
    .field (field)
  );

  address_gen address_gen_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .stall       (stall),
    .accept      (accept),
    .first       (first),
    .stride_kind (stride_kind),
    .stride_val  (stride_val),
    .eew_ls      (eew_ls),
    .nf          (nf),
    .field       (field),
    .xs1         (xs1),
    .index0      (index0),
    .index1      (index1),
    .addr0       (gen_addr0),
    .addr1       (gen_addr1)
  );

  // mask source is the vs2 register group
  mask_scan_fsm mask_scan_fsm_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .flush   (flush),
    .accept  (accept),
    .last    (last),
    .is_mask (is_mask),
    .mask_op (mask_op),
    .m_lo    (vs2_lane0),
    .m_hi    (vs2_lane1),
    .mres_lo (mres_lo),
    .mres_hi (mres_hi)
  );

  result_latch result_latch_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .fu        (fu),
    .aluop     (aluop),
    .minmax    (minmax),
    .sew       (sew),
    .reduce    (reduce),
    .y0        (y0),
    .y1        (y1),
    .mres_lo   (mres_lo),
    .mres_hi   (mres_hi),
    .gen_addr0 (gen_addr0),
    .gen_addr1 (gen_addr1),
    .out_valid (out_valid),
    .result0   (result0),
    .result1   (result1),
    .addr0     (addr0),
    .addr1     (addr1),
    .load_ena  (load_ena),
    .store_ena (store_ena)
  );

endmodule

// ==== vex_op_pkg.sv ====
/* operation encodings of the vector execute stage
   imported by the decode-facing ports and by every module that decodes an op */
package vex_op_pkg;

  // unit that consumes the beat
  typedef enum logic [1:0] {
    FU_ALU   = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_MASK  = 2'd3
  } fu_t;

  // per-lane operation, ALU_MM picks one of minmax_t
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_AND = 3'd1,
    ALU_OR  = 3'd2,
    ALU_XOR = 3'd3,
    ALU_MM  = 3'd4
  } aluop_t;

  typedef enum logic [1:0] {
    MIN  = 2'd0,
    MINU = 2'd1,
    MAX  = 2'd2,
    MAXU = 2'd3
  } minmax_t;

  // operand 1 source
  typedef enum logic [1:0] {
    SRC_V = 2'd0,
    SRC_I = 2'd1,
    SRC_X = 2'd2
  } src_t;

  typedef enum logic [1:0] {
    STRIDE_UNIT  = 2'd0,
    STRIDE_CONST = 2'd1,
    STRIDE_SEG   = 2'd2,
    STRIDE_INDEX = 2'd3
  } stride_t;

  // set-before-first, set-including-first, set-only-first
  typedef enum logic [1:0] {
    MASK_SBF = 2'd0,
    MASK_SIF = 2'd1,
    MASK_SOF = 2'd2
  } mask_op_t;

endpackage

// ==== vex_width_pkg.sv ====
/* data and element widths of the two-lane execute stage
   import wherever a word, a field index or an element width is handled */
package vex_width_pkg;

  localparam int XLEN              = 32;
  localparam int LANES             = 2;
  localparam int NF_W              = 3;
  // a full word, the widest element
  localparam int UNIT_STRIDE_BYTES = 4;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [NF_W-1:0] field_t;

  // also used for the load/store element width
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // log2 of the element size in bytes
  function automatic logic [1:0] sew_shift(sew_t s);
    case (s)
      SEW8:    return 2'd0;
      SEW16:   return 2'd1;
      default: return 2'($clog2(UNIT_STRIDE_BYTES));
    endcase
  endfunction

endpackage
